//--- hdl/z80Pkg.sv
package z80Pkg;

    localparam int byteWidth  = 8;
    localparam int addrWidth  = 16;
    localparam int lenWidth   = 3;
    localparam int maxInsnLen = 4;

    typedef logic [byteWidth-1:0] byte_t;
    typedef logic [addrWidth-1:0] addr_t;

    // length runs 1..4, count runs 0..4
    typedef logic [lenWidth-1:0] insnLen_t;
    typedef logic [lenWidth-1:0] byteCount_t;

    typedef enum logic [7:0] {
        NEED_MORE_BYTES,
        ILLEGAL_INSTR,
        // unprefixed
        NOP, LD_DD_NN, LD_IND_BCDE_A, INC_DEC_DD,
        INC_DEC_REG, RR_RLCA, ADD_HL_DD, DAA,
        CPL, INC_DEC_IND_HL, LD_A_IND_BCDE, LD_REG_N,
        LD_IND_NN_HL, LD_HL_IND_NN, LD_IND_HL_N, LD_REG_REG,
        LD_IND_NN_A, SCF, LD_A_IND_NN, CCF,
        LD_IND_HL_REG, HALT, POP_QQ, PUSH_QQ,
        EX_AF_AF2, EX_IND_SP_HL, EX_DE_HL, EXX,
        LD_SP_HL, ALU_A_REG, ALU_A_IND_HL, ALU_A_N,
        EI_DI,
        // CB prefix
        RR_RLC_REG, RR_RLC_IND_HL, SHIFT_REG, SHIFT_IND_HL,
        // ED prefix
        ADC_SBC_HL_DD, LD_DD_IND_NN, NEG, LD_IND_NN_DD,
        LD_I_A, LD_R_A, LD_A_I, LD_A_R,
        ROT_DEC, LDI, CPI, LDD,
        CPD, LDIR, CPIR, LDDR,
        CPDR,
        // DD / FD prefix
        ADD_IXIY_SS, INC_DEC_IXIY, LD_REG_IDX_IXIY, LD_IDX_IXIY_REG,
        LD_IXIY_NN, LD_IXIY_IND_NN, INC_DEC_IDX_IXIY, LD_IDX_IXIY_N,
        EX_IND_SP_IXIY, POP_IXIY, PUSH_IXIY, LD_IND_NN_IXIY,
        ALU_A_IDX_IXIY, LD_SP_IXIY,
        // DD CB d op / FD CB d op, refined from the fourth byte
        IDX_IXIY_BITS, RR_RLC_IDX_IXIY, SHIFT_IDX_IXIY
    } insnGroup_t;

endpackage

//--- hdl/instrDecoder.sv
module instrDecoder (
    input  logic [31:0]        insnBytes,
    input  z80Pkg::byteCount_t byteCount,
    output z80Pkg::insnLen_t   insnLen,
    output z80Pkg::insnGroup_t insnGroup
);
    import z80Pkg::*;

    typedef struct packed {
        insnGroup_t grp;
        insnLen_t   len;
    } decode_t;

    byte_t      prefix;
    byte_t      op;
    decode_t    oneByte;
    decode_t    twoByte;
    insnGroup_t bitsGroup;

    assign prefix = insnBytes[7:0];
    assign op     = insnBytes[15:8];

    // first byte only
    always_comb begin
        case (prefix)
            8'h00: oneByte = '{NOP, 3'd1};
            8'h01, 8'h11, 8'h21, 8'h31: oneByte = '{LD_DD_NN, 3'd3};
            8'h02, 8'h12: oneByte = '{LD_IND_BCDE_A, 3'd1};
            8'h03, 8'h13, 8'h23, 8'h33,
            8'h0B, 8'h1B, 8'h2B, 8'h3B: oneByte = '{INC_DEC_DD, 3'd1};
            8'h04, 8'h0C, 8'h14, 8'h1C, 8'h24, 8'h2C, 8'h3C,
            8'h05, 8'h0D, 8'h15, 8'h1D, 8'h25, 8'h2D, 8'h3D: oneByte = '{INC_DEC_REG, 3'd1};
            8'h07, 8'h17, 8'h0F, 8'h1F: oneByte = '{RR_RLCA, 3'd1};
            8'h09, 8'h19, 8'h29, 8'h39: oneByte = '{ADD_HL_DD, 3'd1};
            8'h27: oneByte = '{DAA, 3'd1};
            8'h2F: oneByte = '{CPL, 3'd1};
            8'h34, 8'h35: oneByte = '{INC_DEC_IND_HL, 3'd1};
            8'h0A, 8'h1A: oneByte = '{LD_A_IND_BCDE, 3'd1};
            8'h06, 8'h0E, 8'h16, 8'h1E, 8'h26, 8'h2E, 8'h3E: oneByte = '{LD_REG_N, 3'd2};
            8'h22: oneByte = '{LD_IND_NN_HL, 3'd3};
            8'h2A: oneByte = '{LD_HL_IND_NN, 3'd3};
            8'h36: oneByte = '{LD_IND_HL_N, 3'd2};
            8'h32: oneByte = '{LD_IND_NN_A, 3'd3};
            8'h37: oneByte = '{SCF, 3'd1};
            8'h3A: oneByte = '{LD_A_IND_NN, 3'd3};
            8'h3F: oneByte = '{CCF, 3'd1};
            8'h70, 8'h71, 8'h72, 8'h73, 8'h74, 8'h75, 8'h77: oneByte = '{LD_IND_HL_REG, 3'd1};
            8'h76: oneByte = '{HALT, 3'd1};
            8'hC1, 8'hD1, 8'hE1, 8'hF1: oneByte = '{POP_QQ, 3'd1};
            8'hC5, 8'hD5, 8'hE5, 8'hF5: oneByte = '{PUSH_QQ, 3'd1};
            8'h08: oneByte = '{EX_AF_AF2, 3'd1};
            8'hE3: oneByte = '{EX_IND_SP_HL, 3'd1};
            8'hEB: oneByte = '{EX_DE_HL, 3'd1};
            8'hD9: oneByte = '{EXX, 3'd1};
            8'hF9: oneByte = '{LD_SP_HL, 3'd1};
            8'hC6, 8'hCE, 8'hD6, 8'hDE, 8'hE6, 8'hEE, 8'hF6, 8'hFE: oneByte = '{ALU_A_N, 3'd2};
            8'hCB, 8'hDD, 8'hED, 8'hFD: oneByte = '{NEED_MORE_BYTES, 3'd2};
            8'hF3, 8'hFB: oneByte = '{EI_DI, 3'd1};
            default: begin
                // 80..BF is the ALU block, 40..7F the register moves; (HL) sources stay illegal
                if (prefix[7:6] == 2'b10) begin
                    if (prefix[2:0] == 3'b110) begin
                        oneByte = '{ALU_A_IND_HL, 3'd1};
                    end else begin
                        oneByte = '{ALU_A_REG, 3'd1};
                    end
                end else if (prefix[7:6] == 2'b01 && prefix[2:0] != 3'b110) begin
                    oneByte = '{LD_REG_REG, 3'd1};
                end else begin
                    oneByte = '{ILLEGAL_INSTR, 3'd1};
                end
            end
        endcase
    end

    // prefix plus opcode
    always_comb begin
        twoByte = '{ILLEGAL_INSTR, 3'd2};
        if (prefix == 8'hCB) begin
            // rotates in 00..1F, shifts in 20..2F and 38..3F
            if (op[7:5] == 3'b000) begin
                twoByte.grp = (op[2:0] == 3'b110) ? RR_RLC_IND_HL : RR_RLC_REG;
            end else if (op[7:5] == 3'b001 && op[4:3] != 2'b10) begin
                twoByte.grp = (op[2:0] == 3'b110) ? SHIFT_IND_HL : SHIFT_REG;
            end
        end else if (prefix == 8'hED) begin
            case (op)
                8'h42, 8'h52, 8'h62, 8'h72,
                8'h4A, 8'h5A, 8'h6A, 8'h7A: twoByte = '{ADC_SBC_HL_DD, 3'd2};
                8'h4B, 8'h5B, 8'h6B, 8'h7B: twoByte = '{LD_DD_IND_NN, 3'd4};
                8'h43, 8'h53, 8'h63, 8'h73: twoByte = '{LD_IND_NN_DD, 3'd4};
                8'h44: twoByte = '{NEG, 3'd2};
                8'h47: twoByte = '{LD_I_A, 3'd2};
                8'h4F: twoByte = '{LD_R_A, 3'd2};
                8'h57: twoByte = '{LD_A_I, 3'd2};
                8'h5F: twoByte = '{LD_A_R, 3'd2};
                8'h67, 8'h6F: twoByte = '{ROT_DEC, 3'd2};
                8'hA0: twoByte = '{LDI, 3'd2};
                8'hA1: twoByte = '{CPI, 3'd2};
                8'hA8: twoByte = '{LDD, 3'd2};
                8'hA9: twoByte = '{CPD, 3'd2};
                8'hB0: twoByte = '{LDIR, 3'd2};
                8'hB1: twoByte = '{CPIR, 3'd2};
                8'hB8: twoByte = '{LDDR, 3'd2};
                8'hB9: twoByte = '{CPDR, 3'd2};
                default: twoByte = '{ILLEGAL_INSTR, 3'd2};
            endcase
        end else if (prefix == 8'hDD || prefix == 8'hFD) begin
            // IX and IY share one table
            case (op)
                8'h09, 8'h19, 8'h29, 8'h39: twoByte = '{ADD_IXIY_SS, 3'd2};
                8'h23, 8'h2B: twoByte = '{INC_DEC_IXIY, 3'd2};
                8'h46, 8'h4E, 8'h56, 8'h5E,
                8'h66, 8'h6E, 8'h7E: twoByte = '{LD_REG_IDX_IXIY, 3'd3};
                8'h70, 8'h71, 8'h72, 8'h73,
                8'h74, 8'h75, 8'h77: twoByte = '{LD_IDX_IXIY_REG, 3'd3};
                8'h21: twoByte = '{LD_IXIY_NN, 3'd4};
                8'h2A: twoByte = '{LD_IXIY_IND_NN, 3'd4};
                8'h34, 8'h35: twoByte = '{INC_DEC_IDX_IXIY, 3'd3};
                8'h36: twoByte = '{LD_IDX_IXIY_N, 3'd4};
                8'hE3: twoByte = '{EX_IND_SP_IXIY, 3'd2};
                8'hE1: twoByte = '{POP_IXIY, 3'd2};
                8'hE5: twoByte = '{PUSH_IXIY, 3'd2};
                8'h22: twoByte = '{LD_IND_NN_IXIY, 3'd4};
                8'h86, 8'h8E, 8'h96, 8'h9E,
                8'hA6, 8'hAE, 8'hB6, 8'hBE: twoByte = '{ALU_A_IDX_IXIY, 3'd3};
                8'hF9: twoByte = '{LD_SP_IXIY, 3'd2};
                // displacement comes next, the real opcode is the fourth byte
                8'hCB: twoByte = '{IDX_IXIY_BITS, 3'd4};
                default: twoByte = '{ILLEGAL_INSTR, 3'd2};
            endcase
        end
    end

    always_comb begin
        case (insnBytes[31:24])
            8'h06, 8'h16, 8'h0E, 8'h1E: bitsGroup = RR_RLC_IDX_IXIY;
            8'h26, 8'h2E, 8'h3E: bitsGroup = SHIFT_IDX_IXIY;
            default: bitsGroup = ILLEGAL_INSTR;
        endcase
    end

    always_comb begin
        if (byteCount == '0) begin
            insnGroup = NEED_MORE_BYTES;
            insnLen   = 3'd1;
        end else if (byteCount == 3'd1 || oneByte.grp != NEED_MORE_BYTES) begin
            // unprefixed opcodes keep their first-byte decode while operands arrive
            insnGroup = oneByte.grp;
            insnLen   = oneByte.len;
        end else if (twoByte.grp == IDX_IXIY_BITS && byteCount == byteCount_t'(maxInsnLen)) begin
            insnGroup = bitsGroup;
            insnLen   = twoByte.len;
        end else begin
            insnGroup = twoByte.grp;
            insnLen   = twoByte.len;
        end
    end

endmodule

//--- hdl/fetchControl.sv
module fetchControl (
    input  logic               clk,
    input  logic               arstN,
    input  logic               memAck,
    input  logic               insnAck,
    input  z80Pkg::insnLen_t   insnLen,
    input  z80Pkg::insnGroup_t insnGroup,
    input  z80Pkg::byteCount_t byteCount,
    output logic               memReq,
    output logic               insnReq,
    output logic               captureByte,
    output logic               insnDone
);
    import z80Pkg::*;

    typedef enum logic [2:0] {
        stReqByte,
        stWaitAckLow,
        stEvaluate,
        stOffer,
        stWaitRelease
    } state_t;

    state_t state;
    logic   insnComplete;

    // decoder sees the byte captured on the previous edge
    assign insnComplete = (byteCount >= insnLen) && (insnGroup != NEED_MORE_BYTES);

    assign memReq      = (state == stReqByte);
    assign insnReq     = (state == stOffer);
    assign captureByte = memReq && memAck;
    assign insnDone    = insnReq && insnAck;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= stWaitAckLow;
        end else begin
            case (state)
                stWaitAckLow: begin
                    if (!memAck) begin
                        state <= stReqByte;
                    end
                end
                stReqByte: begin
                    if (memAck) begin
                        state <= stEvaluate;
                    end
                end
                stEvaluate: begin
                    if (insnComplete) begin
                        state <= stOffer;
                    end else if (!memAck) begin
                        state <= stReqByte;
                    end else begin
                        state <= stWaitAckLow;
                    end
                end
                stOffer: begin
                    if (insnAck) begin
                        state <= stWaitRelease;
                    end
                end
                stWaitRelease: begin
                    if (!insnAck) begin
                        state <= stWaitAckLow;
                    end
                end
                default: begin
                    state <= stWaitAckLow;
                end
            endcase
        end
    end

    // a request is only withdrawn once the memory has answered
    memReqHold: assert property (@(posedge clk) disable iff (!arstN)
        memReq && !memAck |=> memReq && $stable(byteCount));

    // the decoded length and group must not move while the instruction is offered
    insnReqHold: assert property (@(posedge clk) disable iff (!arstN)
        insnReq && !insnAck |=> insnReq && $stable(insnLen) && $stable(insnGroup));

endmodule

//--- hdl/fetchCounter.sv
module fetchCounter #(
    parameter z80Pkg::addr_t resetPc = 16'h0000
) (
    input  logic               clk,
    input  logic               arstN,
    input  logic               captureByte,
    input  logic               insnDone,
    input  z80Pkg::insnLen_t   insnLen,
    output z80Pkg::addr_t      fetchAddr,
    output z80Pkg::addr_t      memAddr,
    output z80Pkg::byteCount_t byteCount
);
    import z80Pkg::*;

    // next byte sits right after the ones already gathered, wrapping at 64K
    assign memAddr = fetchAddr + addr_t'(byteCount);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            fetchAddr <= resetPc;
            byteCount <= '0;
        end else if (insnDone) begin
            fetchAddr <= fetchAddr + addr_t'(insnLen);
            byteCount <= '0;
        end else if (captureByte) begin
            byteCount <= byteCount + byteCount_t'(1);
        end
    end

    countInRange: assert property (@(posedge clk) disable iff (!arstN)
        byteCount <= byteCount_t'(maxInsnLen));

endmodule

//--- hdl/instrAssembler.sv
module instrAssembler (
    input  logic               clk,
    input  logic               arstN,
    input  logic               captureByte,
    input  logic               insnDone,
    input  z80Pkg::byte_t      memData,
    input  z80Pkg::byteCount_t byteCount,
    output logic [31:0]        insnBytes
);
    import z80Pkg::*;

    // slot 0 holds the first byte of the instruction
    byte_t [maxInsnLen-1:0] slots;

    assign insnBytes = slots;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            slots <= '0;
        end else if (insnDone) begin
            // unused upper slots must read as zero for the next instruction
            slots <= '0;
        end else if (captureByte) begin
            slots[byteCount[1:0]] <= memData;
        end
    end

    // a fifth byte would wrap onto slot 0
    noOverfill: assert property (@(posedge clk) disable iff (!arstN)
        captureByte |-> byteCount < byteCount_t'(maxInsnLen));

endmodule

//--- hdl/z80Fetch.sv
module z80Fetch #(
    parameter z80Pkg::addr_t resetPc = 16'h0000
) (
    input  logic               clk,
    input  logic               arstN,
    input  logic               memAck,
    input  logic               insnAck,
    input  z80Pkg::byte_t      memData,
    output logic               memReq,
    output logic               insnReq,
    output z80Pkg::addr_t      memAddr,
    output z80Pkg::addr_t      insnPc,
    output logic [31:0]        insnBytes,
    output z80Pkg::insnLen_t   insnLen,
    output z80Pkg::insnGroup_t insnGroup
);
    import z80Pkg::*;

    logic       captureByte;
    logic       insnDone;
    byteCount_t byteCount;

    fetchControl u_fetchControl (
        .clk        (clk),
        .arstN      (arstN),
        .memAck     (memAck),
        .insnAck    (insnAck),
        .insnLen    (insnLen),
        .insnGroup  (insnGroup),
        .byteCount  (byteCount),
        .memReq     (memReq),
        .insnReq    (insnReq),
        .captureByte(captureByte),
        .insnDone   (insnDone)
    );

    // the instruction start address doubles as insnPc
    fetchCounter #(
        .resetPc(resetPc)
    ) u_fetchCounter (
        .clk        (clk),
        .arstN      (arstN),
        .captureByte(captureByte),
        .insnDone   (insnDone),
        .insnLen    (insnLen),
        .fetchAddr  (insnPc),
        .memAddr    (memAddr),
        .byteCount  (byteCount)
    );

    instrAssembler u_instrAssembler (
        .clk        (clk),
        .arstN      (arstN),
        .captureByte(captureByte),
        .insnDone   (insnDone),
        .memData    (memData),
        .byteCount  (byteCount),
        .insnBytes  (insnBytes)
    );

    instrDecoder u_instrDecoder (
        .insnBytes(insnBytes),
        .byteCount(byteCount),
        .insnLen  (insnLen),
        .insnGroup(insnGroup)
    );

endmodule

//--- tb/z80FetchChecker.sv
module z80FetchChecker #(
    parameter z80Pkg::addr_t resetPc = 16'h0000,
    parameter int numInsns = 400
) (
    input  logic               clk,
    input  logic               arstN,
    input  logic               memReq,
    input  logic               memAck,
    input  z80Pkg::addr_t      memAddr,
    input  logic               insnReq,
    input  logic               insnAck,
    input  z80Pkg::addr_t      insnPc,
    input  logic [31:0]        insnBytes,
    input  z80Pkg::insnLen_t   insnLen,
    input  z80Pkg::insnGroup_t insnGroup,
    output logic               runDone,
    output logic               runFailed
);
    import z80Pkg::*;

    localparam int numEncodings = 30;
    // worst case per instruction is four slow byte fetches plus a slow consumer
    localparam int cycleLimit = numInsns * (4 * (3 + 5) + 5 + 6);

    typedef struct packed {
        logic [31:0] pat;
        logic [3:0]  mask;
        logic [2:0]  len;
        insnGroup_t  grp;
    } encoding_t;

    byte_t      image [0:65535];
    integer     seed = 31795;
    addr_t      runAddr;
    addr_t      nextByteAddr;
    int         cycles;
    int         checkedCount;
    int         passCount;
    int         failCount;
    int         protocolErrors;
    bit         insnOk;
    bit         timedOut;
    logic       prevInsnReq;
    logic       prevInsnAck;
    logic       prevMemReq;
    logic       prevMemAck;
    logic [31:0] heldBytes;
    addr_t      heldPc;
    insnLen_t   heldLen;
    insnGroup_t heldGroup;

    assign runFailed = timedOut || (failCount != 0) || (protocolErrors != 0);

    // fixed opcode bytes per encoding, operand bytes are left random
    function automatic encoding_t encodingAt(input int idx);
        encoding_t e;
        case (idx)
            0: e = '{32'h00, 4'b0001, 3'd1, NOP};
            1: e = '{32'h21, 4'b0001, 3'd3, LD_DD_NN};
            2: e = '{32'h3E, 4'b0001, 3'd2, LD_REG_N};
            3: e = '{32'h36, 4'b0001, 3'd2, LD_IND_HL_N};
            4: e = '{32'h32, 4'b0001, 3'd3, LD_IND_NN_A};
            5: e = '{32'h41, 4'b0001, 3'd1, LD_REG_REG};
            6: e = '{32'h86, 4'b0001, 3'd1, ALU_A_IND_HL};
            7: e = '{32'h80, 4'b0001, 3'd1, ALU_A_REG};
            8: e = '{32'hFE, 4'b0001, 3'd2, ALU_A_N};
            9: e = '{32'h76, 4'b0001, 3'd1, HALT};
            10: e = '{32'hC5, 4'b0001, 3'd1, PUSH_QQ};
            11: e = '{32'hD9, 4'b0001, 3'd1, EXX};
            12: e = '{32'hC3, 4'b0001, 3'd1, ILLEGAL_INSTR};
            13: e = '{32'h06CB, 4'b0011, 3'd2, RR_RLC_IND_HL};
            14: e = '{32'h21CB, 4'b0011, 3'd2, SHIFT_REG};
            15: e = '{32'h40CB, 4'b0011, 3'd2, ILLEGAL_INSTR};
            16: e = '{32'h4BED, 4'b0011, 3'd4, LD_DD_IND_NN};
            17: e = '{32'h43ED, 4'b0011, 3'd4, LD_IND_NN_DD};
            18: e = '{32'hB0ED, 4'b0011, 3'd2, LDIR};
            19: e = '{32'h44ED, 4'b0011, 3'd2, NEG};
            20: e = '{32'h00ED, 4'b0011, 3'd2, ILLEGAL_INSTR};
            21: e = '{32'h21DD, 4'b0011, 3'd4, LD_IXIY_NN};
            22: e = '{32'h36FD, 4'b0011, 3'd4, LD_IDX_IXIY_N};
            23: e = '{32'h7EDD, 4'b0011, 3'd3, LD_REG_IDX_IXIY};
            24: e = '{32'h86FD, 4'b0011, 3'd3, ALU_A_IDX_IXIY};
            25: e = '{32'hE5DD, 4'b0011, 3'd2, PUSH_IXIY};
            26: e = '{32'h00FD, 4'b0011, 3'd2, ILLEGAL_INSTR};
            27: e = '{32'h0600CBDD, 4'b1011, 3'd4, RR_RLC_IDX_IXIY};
            28: e = '{32'h2E00CBFD, 4'b1011, 3'd4, SHIFT_IDX_IXIY};
            default: e = '{32'h0000CBDD, 4'b1011, 3'd4, ILLEGAL_INSTR};
        endcase
        return e;
    endfunction

    // find the table entry whose fixed bytes match the image at addr
    task automatic decodeImage(input addr_t addr, output logic [31:0] word, output int len,
                               output insnGroup_t grp, output bit found);
        encoding_t   enc;
        logic [31:0] bits;
        found = 0;
        len = 1;
        grp = ILLEGAL_INSTR;
        word = {image[addr + 16'd3], image[addr + 16'd2], image[addr + 16'd1], image[addr]};
        for (int i = 0; i < numEncodings && !found; i++) begin
            enc = encodingAt(i);
            bits = {{8{enc.mask[3]}}, {8{enc.mask[2]}}, {8{enc.mask[1]}}, {8{enc.mask[0]}}};
            found = ((word & bits) == (enc.pat & bits));
            len = int'(enc.len);
            grp = enc.grp;
        end
        word = word & ((len == 4) ? 32'hFFFFFFFF : ((32'h1 << (8 * len)) - 32'h1));
    endtask

    task automatic checkField(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            insnOk = 0;
        end
    endtask

    initial begin
        encoding_t enc;
        int        idx;
        addr_t     addr;
        for (int a = 0; a < 65536; a++) begin
            image[a] = byte_t'($random(seed));
        end
        addr = resetPc;
        for (int k = 0; k < numInsns + 20; k++) begin
            idx = ($random(seed) & 32'h7FFFFFFF) % numEncodings;
            enc = encodingAt(idx);
            for (int b = 0; b < int'(enc.len); b++) begin
                if (enc.mask[b]) begin
                    image[addr] = enc.pat[8*b +: 8];
                end
                addr = addr + 16'd1;
            end
        end
    end

    always @(posedge clk or negedge arstN) begin
        logic [31:0] expBytes;
        int          expLen;
        insnGroup_t  expGroup;
        bit          found;
        if (!arstN) begin
            runAddr        <= resetPc;
            nextByteAddr   <= resetPc;
            prevInsnReq    <= 1'b0;
            prevInsnAck    <= 1'b0;
            prevMemReq     <= 1'b0;
            prevMemAck     <= 1'b0;
            cycles         <= 0;
            checkedCount   <= 0;
            passCount      <= 0;
            failCount      <= 0;
            protocolErrors <= 0;
            timedOut       <= 1'b0;
            runDone        <= 1'b0;
        end else if (!runDone) begin
            cycles      <= cycles + 1;
            prevInsnReq <= insnReq;
            prevInsnAck <= insnAck;
            prevMemReq  <= memReq;
            prevMemAck  <= memAck;
            if (cycles == 0 && (memReq || insnReq)) begin
                $display("memReq or insnReq was high right after reset");
                protocolErrors <= protocolErrors + 1;
            end
            if (memReq && !prevMemReq && memAck) begin
                $display("memReq rose while memAck was still high");
                protocolErrors <= protocolErrors + 1;
            end
            if (prevMemReq && !memReq && !prevMemAck) begin
                $display("memReq fell before memAck was seen");
                protocolErrors <= protocolErrors + 1;
            end
            if (memReq && memAck) begin
                if (memAddr !== nextByteAddr) begin
                    $display("Mismatch memAddr: got %h expected %h", memAddr, nextByteAddr);
                    protocolErrors <= protocolErrors + 1;
                end
                nextByteAddr <= nextByteAddr + 16'd1;
            end
            if (insnReq && memReq) begin
                $display("memReq was high while an instruction was offered");
                protocolErrors <= protocolErrors + 1;
            end
            if (memReq && insnAck) begin
                $display("memReq was high before insnAck was released");
                protocolErrors <= protocolErrors + 1;
            end
            if (prevInsnReq && !insnReq && !prevInsnAck) begin
                $display("insnReq fell before insnAck was seen");
                protocolErrors <= protocolErrors + 1;
            end
            if (insnReq && prevInsnReq && (insnBytes !== heldBytes || insnPc !== heldPc ||
                                           insnLen !== heldLen || insnGroup !== heldGroup)) begin
                $display("instruction outputs changed before insnAck");
                protocolErrors <= protocolErrors + 1;
            end
            if (insnReq && !prevInsnReq) begin
                insnOk = 1;
                heldBytes <= insnBytes;
                heldPc    <= insnPc;
                heldLen   <= insnLen;
                heldGroup <= insnGroup;
                decodeImage(runAddr, expBytes, expLen, expGroup, found);
                if (!found) begin
                    $display("image at %h holds no known encoding", runAddr);
                    insnOk = 0;
                end
                checkField("insnPc", 32'(insnPc), 32'(runAddr));
                checkField("insnBytes", insnBytes, expBytes);
                checkField("insnLen", 32'(insnLen), 32'(expLen));
                checkField("insnGroup", 32'(insnGroup), 32'(expGroup));
                $display("insn %0d pc %h bytes %h len %0d %s %s", checkedCount, insnPc,
                         insnBytes, insnLen, insnGroup.name(), insnOk ? "ok" : "FAILED");
                runAddr      <= runAddr + addr_t'(expLen);
                checkedCount <= checkedCount + 1;
                if (insnOk) begin
                    passCount <= passCount + 1;
                end else begin
                    failCount <= failCount + 1;
                end
            end
            if (checkedCount == numInsns && !insnReq) begin
                $display("checked %0d instructions: %0d passed, %0d failed, %0d protocol errors",
                         checkedCount, passCount, failCount, protocolErrors);
                runDone <= 1'b1;
            end else if (cycles >= cycleLimit) begin
                $display("timeout after %0d cycles, no instruction arrived in time", cycles);
                timedOut <= 1'b1;
                runDone  <= 1'b1;
            end
        end
    end

endmodule

//--- tb/z80FetchTb.sv
module z80FetchTb;
    import z80Pkg::*;

    // start near the top so the fetch address wraps
    localparam addr_t resetPc = 16'hFE80;

    logic       clk;
    logic       arstN;
    logic       memAck;
    logic       insnAck;
    byte_t      memData;
    logic       memReq;
    logic       insnReq;
    addr_t      memAddr;
    addr_t      insnPc;
    logic [31:0] insnBytes;
    insnLen_t   insnLen;
    insnGroup_t insnGroup;
    logic       runDone;
    logic       runFailed;

    byte_t      memImage [0:65535];
    integer     seed = 31795;
    int         memWait;
    int         ackWait;

    z80Fetch #(
        .resetPc(resetPc)
    ) u_z80Fetch (
        .clk      (clk),
        .arstN    (arstN),
        .memAck   (memAck),
        .insnAck  (insnAck),
        .memData  (memData),
        .memReq   (memReq),
        .insnReq  (insnReq),
        .memAddr  (memAddr),
        .insnPc   (insnPc),
        .insnBytes(insnBytes),
        .insnLen  (insnLen),
        .insnGroup(insnGroup)
    );

    z80FetchChecker #(
        .resetPc (resetPc),
        .numInsns(400)
    ) u_checker (
        .clk      (clk),
        .arstN    (arstN),
        .memReq   (memReq),
        .memAck   (memAck),
        .memAddr  (memAddr),
        .insnReq  (insnReq),
        .insnAck  (insnAck),
        .insnPc   (insnPc),
        .insnBytes(insnBytes),
        .insnLen  (insnLen),
        .insnGroup(insnGroup),
        .runDone  (runDone),
        .runFailed(runFailed)
    );

    always #10 clk = ~clk;

    initial begin
        clk     = 1'b0;
        arstN   = 1'b0;
        memAck  = 1'b0;
        insnAck = 1'b0;
        memData = '0;
        memWait = 0;
        ackWait = 0;
        #1;
        // memory gets its own copy of the image the checker built
        for (int a = 0; a < 65536; a++) begin
            memImage[a] = u_checker.image[a];
        end
        repeat (5) @(posedge clk);
        arstN <= 1'b1;
    end

    // checker raises runDone once all instructions are in or time has run out
    always @(posedge clk) begin
        if (runDone) begin
            if (runFailed) begin
                $display("Test failed");
            end else begin
                $display("Test completed successfully");
            end
            $finish;
        end
    end

    // memory answers after 0 to 3 cycles
    always @(posedge clk) begin
        if (arstN) begin
            if (memAck) begin
                if (!memReq) begin
                    memAck <= 1'b0;
                end
            end else if (memReq) begin
                if (memWait == 0) begin
                    memAck  <= 1'b1;
                    memData <= memImage[memAddr];
                    memWait <= ($random(seed) & 32'h7FFFFFFF) % 4;
                end else begin
                    memWait <= memWait - 1;
                end
            end
        end
    end

    // consumer accepts after 0 to 5 cycles
    always @(posedge clk) begin
        if (arstN) begin
            if (insnAck) begin
                if (!insnReq) begin
                    insnAck <= 1'b0;
                end
            end else if (insnReq) begin
                if (ackWait == 0) begin
                    insnAck <= 1'b1;
                    ackWait <= ($random(seed) & 32'h7FFFFFFF) % 6;
                end else begin
                    ackWait <= ackWait - 1;
                end
            end
        end
    end

endmodule

//--- z80Fetch.f
hdl/z80Pkg.sv
hdl/instrDecoder.sv
hdl/fetchControl.sv
hdl/fetchCounter.sv
hdl/instrAssembler.sv
hdl/z80Fetch.sv
tb/z80FetchChecker.sv
tb/z80FetchTb.sv

//--- run.sh
#!/bin/sh
# build and run the z80Fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --assert --top-module z80FetchTb \
    -f z80Fetch.f --Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/simv)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Test completed successfully"; then
    exit 0
fi
exit 1
